/* pio_sm.f */
+incdir+rtl
rtl/pio_isa_pkg.sv
rtl/pio_cfg_pkg.sv
rtl/pio_fifo.sv
rtl/pio_decoder.sv
rtl/pio_shift_reg.sv
rtl/pio_sm_core.sv
rtl/pio_top.sv
bench/pio_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f pio_sm.f --top-module pio_tb -o pio_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/pio_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* bench/pio_tb.sv */
`include "pio_params.svh"

module pio_tb import pio_isa_pkg::*, pio_cfg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 2000;
  localparam int SEL_INVERT = 0;
  localparam int SEL_REVERSE = 1;
  localparam int SEL_COUNT_LEFT = 2;
  localparam int SEL_COUNT_RIGHT = 3;

  logic           clk, reset, en, restart, imem_we, tx_push, rx_pop, drain_en;
  pio_cfg_t       cfg;
  logic [4:0]     imem_addr, pc;
  logic [15:0]    imem_wdata;
  logic [31:0]    tx_data, rx_data, in_pins, pins, dirs;
  pio_fifo_stat_t tx_stat, rx_stat;
  logic [31:0]    exp_q [$];
  int             rx_count;

  pio_top dut_i (
    .clk(clk), .reset(reset), .en(en), .restart(restart), .cfg(cfg),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .tx_push(tx_push), .tx_data(tx_data), .tx_stat(tx_stat),
    .rx_pop(rx_pop), .rx_data(rx_data), .rx_stat(rx_stat),
    .in_pins(in_pins), .pins(pins), .dirs(dirs), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Word layout op, delay, arg1, arg2
  function automatic logic [15:0] encode(input logic [2:0] op, input logic [4:0] delay,
                                         input logic [2:0] arg1, input logic [4:0] arg2);
    return {op, delay, arg1, arg2};
  endfunction

  function automatic logic [31:0] ref_transform(input logic [31:0] word, input int sel);
    logic [31:0] r;
    int          i;
    r = '0;
    case (sel)
      SEL_INVERT:  r = ~word;
      SEL_REVERSE: for (i = 0; i < 32; i++) r[31 - i] = word[i];
      default: begin
        // X counts down from word to 0, one IN of bit 0 per pass
        for (i = int'(word); i >= 0; i--) begin
          if (sel == SEL_COUNT_RIGHT) r = {i[0], r[31:1]};
          else r = {r[30:0], i[0]};
        end
      end
    endcase
    return r;
  endfunction

  function automatic pio_cfg_t base_cfg();
    pio_cfg_t c;
    c = '0;
    c.div          = 16'd1;
    c.wrap_top     = 5'd4;
    c.initial_pins = $urandom();
    c.initial_dirs = $urandom();
    return c;
  endfunction

  task automatic fail_run(input string reason);
    $display("Failure at %0t ns: %s", $time, reason);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_instr(input logic [4:0] addr, input logic [15:0] word);
    imem_we    = 1'b1;
    imem_addr  = addr;
    imem_wdata = word;
    @(negedge clk);
    imem_we    = 1'b0;
  endtask

  task automatic start_program(input pio_cfg_t c);
    en      = 1'b0;
    cfg     = c;
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    en      = 1'b1;
  endtask

  // PULL, OUT X 32, MOV Y op X, IN Y 32, PUSH
  task automatic load_mov_program(input logic [1:0] mov_op, input logic [4:0] in_delay);
    en = 1'b0;
    write_instr(5'd0, encode(OP_PUSH_PULL, 5'd0, 3'b101, 5'd0));
    write_instr(5'd1, encode(OP_OUT, 5'd0, DST_X, 5'd0));
    write_instr(5'd2, encode(OP_MOV, 5'd0, DST_Y, {mov_op, SRC_X}));
    write_instr(5'd3, encode(OP_IN, in_delay, SRC_Y, 5'd0));
    write_instr(5'd4, encode(OP_PUSH_PULL, 5'd0, 3'b001, 5'd0));
  endtask

  task automatic send_word(input logic [31:0] word);
    int cycles;
    cycles = 0;
    while (tx_stat.full) begin
      if (cycles == WAIT_LIMIT) fail_run("TX FIFO never had room for the next word");
      else begin
        @(negedge clk);
        cycles++;
      end
    end
    tx_push = 1'b1;
    tx_data = word;
    @(negedge clk);
    tx_push = 1'b0;
  endtask

  task automatic wait_rx_count(input int target);
    int cycles;
    cycles = 0;
    while (rx_count < target) begin
      if (cycles == WAIT_LIMIT) fail_run("expected RX words did not arrive");
      else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic wait_pc(input logic [4:0] value);
    int cycles;
    cycles = 0;
    while (pc != value) begin
      if (cycles == WAIT_LIMIT) fail_run("program counter never reached the awaited address");
      else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic wait_fifos_full();
    int cycles;
    cycles = 0;
    while (!(rx_stat.full && tx_stat.full)) begin
      if (cycles == WAIT_LIMIT) fail_run("RX and TX FIFOs did not both fill up");
      else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) @(negedge clk);
    check_value("RX empty after idle window", 32'(rx_stat.empty), 32'd1);
  endtask

  // Compare process pops every RX word while draining is on
  initial begin
    rx_pop   = 1'b0;
    rx_count = 0;
    forever begin
      @(negedge clk);
      if (drain_en && !rx_stat.empty) begin
        if (exp_q.size() == 0) fail_run("RX word arrived with none expected");
        else begin
          check_value("RX word", rx_data, exp_q.pop_front());
          rx_count++;
          rx_pop = 1'b1;
        end
      end else rx_pop = 1'b0;
    end
  end

  initial begin
    pio_cfg_t    c;
    logic [31:0] w, exp_pins;
    int          base, k;
    void'($urandom(32'h9450337a));
    reset      = 1'b1;
    en         = 1'b0;
    restart    = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    tx_push    = 1'b0;
    tx_data    = '0;
    in_pins    = '0;
    drain_en   = 1'b0;
    cfg        = base_cfg();
    cfg.wrap_bottom = 5'd2;
    cfg.wrap_top    = 5'd6;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    check_value("RX empty after reset", 32'(rx_stat.empty), 32'd1);
    check_value("TX empty after reset", 32'(tx_stat.empty), 32'd1);
    check_value("pins after reset", pins, cfg.initial_pins);
    check_value("dirs after reset", dirs, cfg.initial_dirs);
    check_value("pc after reset", 32'(pc), 32'(cfg.wrap_bottom));

    drain_en = 1'b1;
    load_mov_program(MOV_INVERT, 5'd0);
    start_program(base_cfg());
    for (k = 0; k < 20; k++) begin
      w = $urandom();
      exp_q.push_back(ref_transform(w, SEL_INVERT));
      send_word(w);
    end
    wait_rx_count(20);
    load_mov_program(MOV_REVERSE, 5'd3);   // Delay on IN
    start_program(base_cfg());
    for (k = 0; k < 20; k++) begin
      w = $urandom();
      exp_q.push_back(ref_transform(w, SEL_REVERSE));
      send_word(w);
    end
    wait_rx_count(40);

    // Pin windows
    c = base_cfg();
    c.wrap_top  = 5'd3;
    c.set_base  = 5'd8;
    c.set_count = 3'd5;
    c.out_base  = 5'd20;
    c.out_count = 3'd5;
    en = 1'b0;
    write_instr(5'd0, encode(OP_PUSH_PULL, 5'd0, 3'b101, 5'd0));
    write_instr(5'd1, encode(OP_SET, 5'd0, DST_PINDIRS, 5'd31));
    write_instr(5'd2, encode(OP_SET, 5'd0, DST_PINS, 5'd21));
    write_instr(5'd3, encode(OP_OUT, 5'd0, DST_PINS, 5'd5));
    start_program(c);
    w = $urandom();
    send_word(w);
    wait_pc(5'd3);
    wait_pc(5'd0);
    exp_pins = c.initial_pins & ~(32'h1f << 8) & ~(32'h1f << 20);
    exp_pins = exp_pins | (32'd21 << 8) | ({27'd0, w[31:27]} << 20);
    check_value("pins after SET and OUT", pins, exp_pins);
    check_value("dirs after SET", dirs, (c.initial_dirs & ~(32'h1f << 8)) | (32'd31 << 8));

    // Countdown loop, both shift directions
    en = 1'b0;
    write_instr(5'd0, encode(OP_SET, 5'd0, DST_X, 5'd5));
    write_instr(5'd1, encode(OP_IN, 5'd0, SRC_X, 5'd1));
    write_instr(5'd2, encode(OP_JMP, 5'd1, COND_X_DEC, 5'd1));
    write_instr(5'd3, encode(OP_PUSH_PULL, 5'd0, 3'b001, 5'd0));
    write_instr(5'd4, encode(OP_JMP, 5'd0, COND_ALWAYS, 5'd4));   // Park
    c = base_cfg();
    c.div = 16'd3;
    exp_q.push_back(ref_transform(32'd5, SEL_COUNT_LEFT));
    start_program(c);
    wait_rx_count(41);
    c.shift_right = 1'b1;
    exp_q.push_back(ref_transform(32'd5, SEL_COUNT_RIGHT));
    start_program(c);
    wait_rx_count(42);

    // Back-pressure with RX held
    drain_en = 1'b0;
    load_mov_program(MOV_INVERT, 5'd0);
    start_program(base_cfg());
    base = rx_count;
    fork
      begin
        for (k = 0; k < 3 * `PIO_FIFO_DEPTH; k++) begin
          w = $urandom();
          exp_q.push_back(ref_transform(w, SEL_INVERT));
          send_word(w);
        end
      end
      begin
        wait_fifos_full();
        check_value("RX level while held", 32'(rx_stat.level), `PIO_FIFO_DEPTH);
        check_value("TX level while held", 32'(tx_stat.level), `PIO_FIFO_DEPTH);
        drain_en = 1'b1;
      end
    join
    wait_rx_count(base + 3 * `PIO_FIFO_DEPTH);
    expect_quiet(200);

    // WAIT on GPIO 3
    en = 1'b0;
    write_instr(5'd0, encode(OP_WAIT, 5'd0, 3'b100, 5'd3));
    write_instr(5'd1, encode(OP_IN, 5'd0, SRC_PINS, 5'd0));
    write_instr(5'd2, encode(OP_PUSH_PULL, 5'd0, 3'b001, 5'd0));
    write_instr(5'd3, encode(OP_JMP, 5'd0, COND_ALWAYS, 5'd3));
    c = base_cfg();
    c.wrap_top = 5'd3;
    in_pins = $urandom() & ~32'h8;
    start_program(c);
    expect_quiet(100);
    w = $urandom() | 32'h8;
    exp_q.push_back(w);
    base = rx_count;
    in_pins = w;
    wait_rx_count(base + 1);
    expect_quiet(100);

    if (exp_q.size() != 0) fail_run("expected RX words were never received");
    else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* rtl/pio_top.sv */
`include "pio_params.svh"

module pio_top import pio_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  logic                   restart,
  input  pio_cfg_t               cfg,
  input  logic                   imem_we,
  input  logic [4:0]             imem_addr,
  input  logic [15:0]            imem_wdata,
  input  logic                   tx_push,
  input  logic [`PIO_DATA_W-1:0] tx_data,
  output pio_fifo_stat_t         tx_stat,
  input  logic                   rx_pop,
  output logic [`PIO_DATA_W-1:0] rx_data,
  output pio_fifo_stat_t         rx_stat,
  input  logic [`PIO_DATA_W-1:0] in_pins,
  output logic [`PIO_DATA_W-1:0] pins,
  output logic [`PIO_DATA_W-1:0] dirs,
  output logic [4:0]             pc
);

  logic [`PIO_DATA_W-1:0] tx_head;
  logic [`PIO_DATA_W-1:0] isr_data;
  logic                   pull;
  logic                   push;

  pio_fifo tx_fifo_i (
    .clk(clk), .reset(reset),
    .push(tx_push), .push_data(tx_data),
    .pop(pull), .pop_data(tx_head),   // Core pulls the head word
    .stat(tx_stat)
  );

  pio_sm_core core_i (
    .clk(clk), .reset(reset), .en(en), .restart(restart), .cfg(cfg),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .in_pins(in_pins),
    .tx_data(tx_head), .tx_stat(tx_stat), .rx_stat(rx_stat),
    .pull(pull), .push(push), .isr_data(isr_data),
    .pins(pins), .dirs(dirs), .pc(pc)
  );

  pio_fifo rx_fifo_i (
    .clk(clk), .reset(reset),
    .push(push), .push_data(isr_data),
    .pop(rx_pop), .pop_data(rx_data),
    .stat(rx_stat)
  );

endmodule

/* rtl/pio_sm_core.sv */
`include "pio_params.svh"

module pio_sm_core import pio_isa_pkg::*, pio_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  logic                   restart,
  input  pio_cfg_t               cfg,
  input  logic                   imem_we,
  input  logic [4:0]             imem_addr,
  input  logic [15:0]            imem_wdata,
  input  logic [`PIO_DATA_W-1:0] in_pins,
  input  logic [`PIO_DATA_W-1:0] tx_data,
  input  pio_fifo_stat_t         tx_stat,
  input  pio_fifo_stat_t         rx_stat,
  output logic                   pull,
  output logic                   push,
  output logic [`PIO_DATA_W-1:0] isr_data,
  output logic [`PIO_DATA_W-1:0] pins,
  output logic [`PIO_DATA_W-1:0] dirs,
  output logic [4:0]             pc
);

  logic [15:0]            imem [`PIO_IMEM_WORDS];
  logic [15:0]            instr_word;
  pio_instr_t             instr;
  logic                   core_reset;
  logic [15:0]            div_cnt;
  logic                   div_hit, tick, exec;
  logic [4:0]             delay_cnt;
  logic [`PIO_DATA_W-1:0] x, y;
  logic [`PIO_DATA_W-1:0] osr_data, osr_out;
  logic [5:0]             osr_count;
  pio_src_e               src_code;
  logic [`PIO_DATA_W-1:0] src_val, new_val;
  logic [4:0]             wait_idx;
  logic                   waiting, jmp, set_x, set_y, dec_x, dec_y;
  logic                   isr_load, isr_shift, osr_load, osr_shift;
  logic                   pins_we, dirs_we, use_set_win, push_req, pull_req;
  logic [4:0]             win_base;
  logic [2:0]             win_count;
  logic [`PIO_DATA_W-1:0] win_mask, win_val;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] b);
    return (v << b) | (v >> (6'd32 - {1'b0, b}));
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] b);
    return (v >> b) | (v << (6'd32 - {1'b0, b}));
  endfunction

  function automatic logic [31:0] apply_mov(input logic [31:0] v, input pio_mov_op_e op);
    logic [31:0] r;
    r = v;
    if (op == MOV_INVERT) r = ~v;
    else if (op == MOV_REVERSE) begin
      for (int i = 0; i < 32; i++) r[i] = v[31-i];
    end
    return r;
  endfunction

  assign core_reset = reset | restart;
  assign instr_word = imem[pc];
  assign div_hit    = ({1'b0, div_cnt} + 17'd1) >= {1'b0, cfg.div};
  assign tick       = en & div_hit;
  assign exec       = tick & (delay_cnt == 5'd0) & ~waiting;
  assign pull       = exec & pull_req;
  assign push       = exec & push_req;
  assign wait_idx   = instr.arg1[0] ? cfg.in_base + instr.arg2 : instr.arg2;

  pio_decoder decoder_i (.instr_word(instr_word), .instr(instr));

  always_comb begin
    src_code = (instr.op == OP_MOV) ? pio_src_e'(instr.arg2[2:0]) : pio_src_e'(instr.arg1);
    case (src_code)
      SRC_PINS: src_val = rotr(in_pins, cfg.in_base);
      SRC_X:    src_val = x;
      SRC_Y:    src_val = y;
      SRC_ISR:  src_val = isr_data;
      SRC_OSR:  src_val = osr_data;
      default:  src_val = '0;   // NULL and reserved
    endcase
  end

  always_comb begin
    {waiting, jmp, set_x, set_y, dec_x, dec_y} = '0;
    {isr_load, isr_shift, osr_load, osr_shift} = '0;
    {pins_we, dirs_we, use_set_win, push_req, pull_req} = '0;
    new_val = '0;
    case (instr.op)
      OP_JMP: begin
        new_val = {27'd0, instr.arg2};
        case (pio_cond_e'(instr.arg1))
          COND_ALWAYS:        jmp = 1'b1;
          COND_X_ZERO:        jmp = (x == '0);
          COND_X_DEC:         {jmp, dec_x} = {x != '0, 1'b1};   // Post-decrement
          COND_Y_ZERO:        jmp = (y == '0);
          COND_Y_DEC:         {jmp, dec_y} = {y != '0, 1'b1};
          COND_X_NE_Y:        jmp = (x != y);
          COND_PIN:           jmp = in_pins[cfg.jmp_pin];
          COND_OSR_NOT_EMPTY: jmp = (osr_count < 6'd32);
          default:            jmp = 1'b0;
        endcase
      end
      OP_WAIT: waiting = (in_pins[wait_idx] != instr.arg1[2]);
      OP_IN: {new_val, isr_shift} = {src_val, 1'b1};
      OP_OUT, OP_MOV: begin
        new_val   = (instr.op == OP_OUT) ? osr_out
                    : apply_mov(src_val, pio_mov_op_e'(instr.arg2[4:3]));
        osr_shift = (instr.op == OP_OUT);
        case (pio_dst_e'(instr.arg1))
          DST_PINS:    pins_we = 1'b1;   // OUT window
          DST_X:       set_x = 1'b1;
          DST_Y:       set_y = 1'b1;
          DST_PINDIRS: dirs_we = 1'b1;
          DST_PC:      jmp = 1'b1;
          DST_ISR:     isr_load = 1'b1;
          DST_OSR:     osr_load = (instr.op == OP_MOV);
          default: begin
          end
        endcase
      end
      OP_PUSH_PULL: begin
        if (instr.arg1[2]) begin
          osr_load = 1'b1;
          waiting  = instr.arg1[0] & tx_stat.empty;
          pull_req = ~tx_stat.empty;
          new_val  = tx_stat.empty ? x : tx_data;   // Non-blocking empty copies X
        end else begin
          isr_load = 1'b1;   // ISR clears even when the word is dropped
          waiting  = instr.arg1[0] & rx_stat.full;
          push_req = ~rx_stat.full;
        end
      end
      OP_SET: begin
        new_val     = {27'd0, instr.arg2};
        use_set_win = 1'b1;
        case (pio_dst_e'(instr.arg1))
          DST_PINS:    pins_we = 1'b1;
          DST_X:       set_x = 1'b1;
          DST_Y:       set_y = 1'b1;
          DST_PINDIRS: dirs_we = 1'b1;
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  assign win_base  = use_set_win ? cfg.set_base : cfg.out_base;
  assign win_count = use_set_win ? cfg.set_count : cfg.out_count;
  assign win_mask  = rotl(~(32'hffffffff << win_count), win_base);
  assign win_val   = rotl(new_val, win_base);

  pio_shift_reg #(.RESET_COUNT(0)) isr_i (
    .clk(clk), .reset(core_reset), .tick(exec),
    .load(isr_load), .load_data(new_val),
    .do_shift(isr_shift), .shift_right(cfg.shift_right), .shift_bits(instr.arg2),
    .shift_in(new_val), .data(isr_data), .shifted_out(), .count()
  );

  pio_shift_reg #(.RESET_COUNT(32)) osr_i (
    .clk(clk), .reset(core_reset), .tick(exec),
    .load(osr_load), .load_data(new_val),
    .do_shift(osr_shift), .shift_right(cfg.shift_right), .shift_bits(instr.arg2),
    .shift_in('0), .data(osr_data), .shifted_out(osr_out), .count(osr_count)
  );

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_wdata;
  end

  always_ff @(posedge clk) begin
    if (core_reset) begin
      div_cnt   <= '0;
      delay_cnt <= '0;
      pc        <= cfg.wrap_bottom;
      x         <= '0;
      y         <= '0;
      pins      <= cfg.initial_pins;
      dirs      <= cfg.initial_dirs;
    end else begin
      if (en) div_cnt <= div_hit ? 16'd0 : div_cnt + 16'd1;
      if (tick && delay_cnt != 5'd0) delay_cnt <= delay_cnt - 5'd1;
      if (exec) begin
        delay_cnt <= instr.delay;
        if (jmp) pc <= new_val[4:0];
        else if (pc == cfg.wrap_top) pc <= cfg.wrap_bottom;
        else pc <= pc + 5'd1;
        if (set_x) x <= new_val;
        else if (dec_x) x <= x - 1'b1;
        if (set_y) y <= new_val;
        else if (dec_y) y <= y - 1'b1;
        if (pins_we) pins <= (pins & ~win_mask) | (win_val & win_mask);
        if (dirs_we) dirs <= (dirs & ~win_mask) | (win_val & win_mask);
      end
    end
  end

endmodule

/* rtl/pio_shift_reg.sv */
`include "pio_params.svh"

module pio_shift_reg #(
  parameter int RESET_COUNT = 0   // 32 makes an OSR read as empty
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   tick,
  input  logic                   load,
  input  logic [`PIO_DATA_W-1:0] load_data,
  input  logic                   do_shift,
  input  logic                   shift_right,
  input  logic [4:0]             shift_bits,
  input  logic [`PIO_DATA_W-1:0] shift_in,
  output logic [`PIO_DATA_W-1:0] data,
  output logic [`PIO_DATA_W-1:0] shifted_out,
  output logic [5:0]             count
);

  localparam logic [5:0] FULL = 6'(`PIO_DATA_W);

  logic [5:0]             n;
  logic [`PIO_DATA_W-1:0] mask;
  logic [`PIO_DATA_W-1:0] next_data;
  logic [6:0]             sum;

  always_comb begin
    n    = (shift_bits == 5'd0) ? FULL : {1'b0, shift_bits};
    mask = ~({`PIO_DATA_W{1'b1}} << n);
    sum  = {1'b0, count} + {1'b0, n};
    if (shift_right) begin
      next_data   = (data >> n) | (shift_in << (FULL - n));   // New bits enter at the MSB
      shifted_out = data & mask;
    end else begin
      next_data   = (data << n) | (shift_in & mask);
      shifted_out = data >> (FULL - n);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data  <= '0;
      count <= 6'(RESET_COUNT);
    end else if (tick) begin
      if (load) begin
        data  <= load_data;
        count <= '0;
      end else if (do_shift) begin
        data  <= next_data;
        count <= (sum > {1'b0, FULL}) ? FULL : sum[5:0];   // Saturates at full
      end
    end
  end

endmodule

/* rtl/pio_decoder.sv */
module pio_decoder import pio_isa_pkg::*; (
  input  logic [15:0] instr_word,
  output pio_instr_t  instr
);

  // Word layout: op[15:13] delay[12:8] arg1[7:5] arg2[4:0]
  always_comb begin
    instr.op    = pio_op_e'(instr_word[15:13]);
    instr.delay = instr_word[12:8];
    instr.arg1  = instr_word[7:5];
    instr.arg2  = instr_word[4:0];

    case (instr.op)
      OP_PUSH_PULL: begin
        // Bit 2 picks PULL, bit 0 is block; IfFull/IfEmpty unsupported
        instr.arg1 = {instr_word[7], 1'b0, instr_word[5]};
      end
      OP_WAIT: begin
        if (instr_word[6]) begin   // IRQ wait sources become MOV Y, Y
          instr.op   = OP_MOV;
          instr.arg1 = DST_Y;
          instr.arg2 = {MOV_COPY, SRC_Y};
        end
      end
      OP_IRQ_RSVD: begin
        instr.op   = OP_MOV;
        instr.arg1 = DST_Y;
        instr.arg2 = {MOV_COPY, SRC_Y};
      end
      default: begin
      end
    endcase
  end

endmodule

/* rtl/pio_fifo.sv */
`include "pio_params.svh"

module pio_fifo import pio_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic [`PIO_DATA_W-1:0] push_data,
  input  logic                   pop,
  output logic [`PIO_DATA_W-1:0] pop_data,
  output pio_fifo_stat_t         stat
);

  localparam int PTR_W = $clog2(`PIO_FIFO_DEPTH);

  logic [`PIO_DATA_W-1:0] mem [`PIO_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [2:0]             level;
  logic                   do_push;
  logic                   do_pop;

  assign stat.empty = (level == 3'd0);
  assign stat.full  = (level == 3'(`PIO_FIFO_DEPTH));
  assign stat.level = level;

  assign do_push  = push & ~stat.full;   // Full drops the word
  assign do_pop   = pop & ~stat.empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) level <= level + 3'd1;
      else if (do_pop && !do_push) level <= level - 3'd1;
    end
  end

endmodule

/* rtl/pio_cfg_pkg.sv */
package pio_cfg_pkg;

  typedef struct packed {
    logic [4:0]  out_base;
    logic [4:0]  set_base;
    logic [4:0]  in_base;
    logic [2:0]  out_count;
    logic [2:0]  set_count;
    logic [4:0]  jmp_pin;
    logic        shift_right;   // Applies to both ISR and OSR
    logic [4:0]  wrap_top;
    logic [4:0]  wrap_bottom;
    logic [15:0] div;           // 0 and 1 both tick every cycle
    logic [31:0] initial_pins;
    logic [31:0] initial_dirs;
  } pio_cfg_t;

  typedef struct packed {
    logic       empty;
    logic       full;
    logic [2:0] level;
  } pio_fifo_stat_t;

endpackage

/* rtl/pio_isa_pkg.sv */
package pio_isa_pkg;

  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,
    OP_MOV       = 3'd5,
    OP_IRQ_RSVD  = 3'd6,
    OP_SET       = 3'd7
  } pio_op_e;

  typedef enum logic [2:0] {
    COND_ALWAYS        = 3'd0,
    COND_X_ZERO        = 3'd1,
    COND_X_DEC         = 3'd2,
    COND_Y_ZERO        = 3'd3,
    COND_Y_DEC         = 3'd4,
    COND_X_NE_Y        = 3'd5,
    COND_PIN           = 3'd6,
    COND_OSR_NOT_EMPTY = 3'd7
  } pio_cond_e;

  typedef enum logic [2:0] {
    SRC_PINS = 3'd0,
    SRC_X    = 3'd1,
    SRC_Y    = 3'd2,
    SRC_NULL = 3'd3,
    SRC_ISR  = 3'd6,
    SRC_OSR  = 3'd7
  } pio_src_e;

  typedef enum logic [2:0] {
    DST_PINS    = 3'd0,
    DST_X       = 3'd1,
    DST_Y       = 3'd2,
    DST_PINDIRS = 3'd4,
    DST_PC      = 3'd5,
    DST_ISR     = 3'd6,
    DST_OSR     = 3'd7
  } pio_dst_e;

  typedef enum logic [1:0] {
    MOV_COPY    = 2'd0,
    MOV_INVERT  = 2'd1,
    MOV_REVERSE = 2'd2
  } pio_mov_op_e;

  typedef struct packed {
    pio_op_e    op;
    logic [2:0] arg1;   // Condition, source or destination
    logic [4:0] arg2;   // Target, bit count, data or mov op + source
    logic [4:0] delay;
  } pio_instr_t;

endpackage

/* rtl/pio_params.svh */
`ifndef PIO_PARAMS_SVH
`define PIO_PARAMS_SVH

// FIFO entries per direction
`define PIO_FIFO_DEPTH 4

// Instruction store words
`define PIO_IMEM_WORDS 32

// Width of FIFO words, scratch and shift registers
`define PIO_DATA_W 32

`endif
